/* src/dphy_capture_pkg.sv */
package dphy_capture_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] lane_word_t;   // {3'b0, errsotsync, errsot, sync, active, valid, data}
	typedef logic [31:0] cap_word_t;    // Lane 1 high and lane 0 low
	typedef logic [15:0] pkt_len_t;
	typedef logic [9:0]  bus_adr_t;
	typedef logic [31:0] bus_dat_t;
	typedef logic [5:0]  buf_idx_t;
	typedef logic [6:0]  buf_cnt_t;

	localparam int BUF_DEPTH = 64;

	// Position of the active flag inside a lane word
	localparam int LW_ACTIVE_BIT = 9;

	localparam bus_dat_t GLOBAL_ID = 32'h01234567;

	// --------------------------------------------------
	// Address map
	// --------------------------------------------------
	// Page in address bits 9..8
	localparam logic [1:0] PAGE_REGS = 2'd0;
	localparam logic [1:0] PAGE_BUF  = 2'd1;

	// Register offsets in address bits 7..0
	localparam logic [7:0] ADR_ID     = 8'd0;
	localparam logic [7:0] ADR_CTRL   = 8'd1;
	localparam logic [7:0] ADR_STATUS = 8'd2;
	localparam logic [7:0] ADR_LEN0   = 8'd3;
	localparam logic [7:0] ADR_LEN1   = 8'd4;

	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT  = 1;  // Self-clearing

endpackage

/* src/dphy_lane_if.sv */
`timescale 1ns/1ps

interface dphy_lane_if;
	import dphy_capture_pkg::*;

	byte_t rxdatahs;
	logic  rxvalidhs;
	logic  rxactivehs;
	logic  rxsynchs;
	logic  errsoths;
	logic  errsotsynchs;

	// PHY side driven from the top level ports
	modport phy (
		output rxdatahs, rxvalidhs, rxactivehs, rxsynchs,
		output errsoths, errsotsynchs
	);

	modport mon (
		input rxdatahs, rxvalidhs, rxactivehs, rxsynchs,
		input errsoths, errsotsynchs
	);

endinterface

/* src/capture_ctrl_if.sv */
`timescale 1ns/1ps

interface capture_ctrl_if;
	import dphy_capture_pkg::*;

	logic      enable;
	logic      clear;      // One-cycle pulse
	buf_idx_t  rd_idx;
	cap_word_t rd_data;
	buf_cnt_t  word_count;
	logic      full;

	modport regs (
		output enable, clear, rd_idx,
		input  rd_data, word_count, full
	);

	modport buffer (
		input  enable, clear, rd_idx,
		output rd_data, word_count, full
	);

endinterface

/* src/dphy_lane_monitor.sv */
`timescale 1ns/1ps

module dphy_lane_monitor (
	input  logic                          rxbyteclkhs,
	input  logic                          rst_n_i,
	dphy_lane_if.mon                      lane,
	output dphy_capture_pkg::lane_word_t  lane_word_o,
	output dphy_capture_pkg::pkt_len_t    pkt_len_o
);
	import dphy_capture_pkg::*;

	pkt_len_t byte_cnt;
	logic     active_q;
	logic     active_fall;

	assign active_fall = active_q && !lane.rxactivehs;

	// --------------------------------------------------
	// Status word and packet length
	// --------------------------------------------------
	always_ff @(posedge rxbyteclkhs or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lane_word_o <= '0;
			byte_cnt    <= '0;
			active_q    <= 1'b0;
			pkt_len_o   <= '0;
		end else begin
			lane_word_o <= {
				3'b000,
				lane.errsotsynchs,
				lane.errsoths,
				lane.rxsynchs,
				lane.rxactivehs,
				lane.rxvalidhs,
				lane.rxdatahs
			};
			active_q <= lane.rxactivehs;

			// Sync byte restarts the count and is not counted itself
			if (lane.rxsynchs) begin
				byte_cnt <= '0;
			end else if (lane.rxvalidhs && lane.rxactivehs) begin
				byte_cnt <= byte_cnt + pkt_len_t'(1);
			end

			if (active_fall) begin
				pkt_len_o <= byte_cnt;  // End of packet
			end
		end
	end

	// Sync only ever shows up inside an active burst
	a_sync_in_active: assert property (
		@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		lane.rxsynchs |-> lane.rxactivehs
	) else $error("sync high while active is low");

endmodule

/* src/capture_buffer.sv */
`timescale 1ns/1ps

module capture_buffer (
	input  logic                          rxbyteclkhs,
	input  logic                          rst_n_i,
	input  dphy_capture_pkg::lane_word_t  lane0_word_i,
	input  dphy_capture_pkg::lane_word_t  lane1_word_i,
	capture_ctrl_if.buffer                ctrl
);
	import dphy_capture_pkg::*;

	cap_word_t mem [BUF_DEPTH];
	cap_word_t cap_word;
	buf_cnt_t  word_count;
	logic      full;
	logic      any_active;
	logic      wr_en;

	// --------------------------------------------------
	// Packing and write qualification
	// --------------------------------------------------
	assign cap_word   = {lane1_word_i, lane0_word_i};
	assign any_active = lane0_word_i[LW_ACTIVE_BIT] || lane1_word_i[LW_ACTIVE_BIT];

	// Words past full are dropped since the PHY never stalls
	assign wr_en = ctrl.enable && any_active && !full;

	always_ff @(posedge rxbyteclkhs or negedge rst_n_i) begin
		if (!rst_n_i) begin
			word_count <= '0;
			full       <= 1'b0;
		end else if (ctrl.clear) begin
			word_count <= '0;
			full       <= 1'b0;
		end else if (wr_en) begin
			word_count <= word_count + buf_cnt_t'(1);
			full       <= (word_count == buf_cnt_t'(BUF_DEPTH - 1));
		end
	end

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge rxbyteclkhs) begin
		if (wr_en) begin
			mem[buf_idx_t'(word_count)] <= cap_word;
		end
	end

	// Read port for the register bus
	assign ctrl.rd_data    = mem[ctrl.rd_idx];
	assign ctrl.word_count = word_count;
	assign ctrl.full       = full;

	a_count_bound: assert property (
		@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		word_count <= buf_cnt_t'(BUF_DEPTH)
	) else $error("word_count beyond buffer depth");

	// Full holds the count at depth until the next clear
	a_full_holds: assert property (
		@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		full && !ctrl.clear |=> full && (word_count == buf_cnt_t'(BUF_DEPTH))
	) else $error("full dropped without a clear");

endmodule

/* src/capture_regs.sv */
`timescale 1ns/1ps

module capture_regs (
	input  logic                          rxbyteclkhs,
	input  logic                          rst_n_i,
	input  logic                          host_stb_i,
	input  logic                          host_we_i,
	input  dphy_capture_pkg::bus_adr_t    host_adr_i,
	input  dphy_capture_pkg::bus_dat_t    host_dat_i,
	output dphy_capture_pkg::bus_dat_t    host_dat_o,
	output logic                          host_ack_o,
	input  dphy_capture_pkg::pkt_len_t    len0_i,
	input  dphy_capture_pkg::pkt_len_t    len1_i,
	capture_ctrl_if.regs                  ctrl
);
	import dphy_capture_pkg::*;

	typedef enum logic {
		IDLE,
		ACK
	} state_t;

	state_t   state;
	logic     enable_q;
	logic     clear_q;
	logic     req_start;
	logic     ctrl_sel;
	bus_dat_t rd_mux;
	bus_dat_t rd_dat_q;

	assign req_start = (state == IDLE) && host_stb_i;
	assign ctrl_sel  = (host_adr_i[9:8] == PAGE_REGS) && (host_adr_i[7:0] == ADR_CTRL);

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------
	always_comb begin
		rd_mux = '0;  // Unmapped reads as zero
		case (host_adr_i[9:8])
			PAGE_REGS: begin
				case (host_adr_i[7:0])
					ADR_ID:     rd_mux = GLOBAL_ID;
					ADR_CTRL:   rd_mux[CTRL_ENABLE_BIT] = enable_q;
					ADR_STATUS: rd_mux = {23'd0, ctrl.full, 1'b0, ctrl.word_count};
					ADR_LEN0:   rd_mux = {16'd0, len0_i};
					ADR_LEN1:   rd_mux = {16'd0, len1_i};
					default:    rd_mux = '0;
				endcase
			end
			PAGE_BUF: rd_mux = ctrl.rd_data;
			default:  rd_mux = '0;
		endcase
	end

	assign ctrl.rd_idx = host_adr_i[5:0];

	// --------------------------------------------------
	// Four-phase handshake
	// --------------------------------------------------
	always_ff @(posedge rxbyteclkhs or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= IDLE;
			enable_q <= 1'b0;
			clear_q  <= 1'b0;
		end else begin
			clear_q <= 1'b0;
			case (state)
				IDLE: begin
					if (host_stb_i) begin
						state <= ACK;
						if (host_we_i && ctrl_sel) begin
							enable_q <= host_dat_i[CTRL_ENABLE_BIT];
							clear_q  <= host_dat_i[CTRL_CLEAR_BIT];
						end
					end
				end
				ACK: begin
					if (!host_stb_i) state <= IDLE;  // Wait for host release
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read data captured on entry to ACK
	always_ff @(posedge rxbyteclkhs) begin
		if (req_start) rd_dat_q <= rd_mux;
	end

	assign host_dat_o   = rd_dat_q;
	assign host_ack_o   = (state == ACK);
	assign ctrl.enable  = enable_q;
	assign ctrl.clear   = clear_q;

	a_ack_after_stb: assert property (
		@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		$rose(host_ack_o) |-> $past(host_stb_i)
	) else $error("ack rose without a strobe");

endmodule

/* src/dphy_capture_top.sv */
`timescale 1ns/1ps

module dphy_capture_top (
	input  logic                        rxbyteclkhs,
	input  logic                        rst_n_i,

	input  dphy_capture_pkg::byte_t     dl0_rxdatahs_i,
	input  logic                        dl0_rxvalidhs_i,
	input  logic                        dl0_rxactivehs_i,
	input  logic                        dl0_rxsynchs_i,
	input  logic                        dl0_errsoths_i,
	input  logic                        dl0_errsotsynchs_i,

	input  dphy_capture_pkg::byte_t     dl1_rxdatahs_i,
	input  logic                        dl1_rxvalidhs_i,
	input  logic                        dl1_rxactivehs_i,
	input  logic                        dl1_rxsynchs_i,
	input  logic                        dl1_errsoths_i,
	input  logic                        dl1_errsotsynchs_i,

	input  logic                        host_stb_i,
	input  logic                        host_we_i,
	input  dphy_capture_pkg::bus_adr_t  host_adr_i,
	input  dphy_capture_pkg::bus_dat_t  host_dat_i,
	output dphy_capture_pkg::bus_dat_t  host_dat_o,
	output logic                        host_ack_o
);
	import dphy_capture_pkg::*;

	lane_word_t lane0_word;
	lane_word_t lane1_word;
	pkt_len_t   len0;
	pkt_len_t   len1;

	dphy_lane_if    lane0_if ();
	dphy_lane_if    lane1_if ();
	capture_ctrl_if ctrl_if ();

	// --------------------------------------------------
	// PHY lanes
	// --------------------------------------------------
	assign lane0_if.rxdatahs     = dl0_rxdatahs_i;
	assign lane0_if.rxvalidhs    = dl0_rxvalidhs_i;
	assign lane0_if.rxactivehs   = dl0_rxactivehs_i;
	assign lane0_if.rxsynchs     = dl0_rxsynchs_i;
	assign lane0_if.errsoths     = dl0_errsoths_i;
	assign lane0_if.errsotsynchs = dl0_errsotsynchs_i;

	assign lane1_if.rxdatahs     = dl1_rxdatahs_i;
	assign lane1_if.rxvalidhs    = dl1_rxvalidhs_i;
	assign lane1_if.rxactivehs   = dl1_rxactivehs_i;
	assign lane1_if.rxsynchs     = dl1_rxsynchs_i;
	assign lane1_if.errsoths     = dl1_errsoths_i;
	assign lane1_if.errsotsynchs = dl1_errsotsynchs_i;

	dphy_lane_monitor u_lane0 (
		.rxbyteclkhs (rxbyteclkhs),
		.rst_n_i     (rst_n_i),
		.lane        (lane0_if.mon),
		.lane_word_o (lane0_word),
		.pkt_len_o   (len0)
	);

	dphy_lane_monitor u_lane1 (
		.rxbyteclkhs (rxbyteclkhs),
		.rst_n_i     (rst_n_i),
		.lane        (lane1_if.mon),
		.lane_word_o (lane1_word),
		.pkt_len_o   (len1)
	);

	// --------------------------------------------------
	// Capture memory and register bus
	// --------------------------------------------------
	capture_buffer u_buffer (
		.rxbyteclkhs  (rxbyteclkhs),
		.rst_n_i      (rst_n_i),
		.lane0_word_i (lane0_word),
		.lane1_word_i (lane1_word),
		.ctrl         (ctrl_if.buffer)
	);

	capture_regs u_regs (
		.rxbyteclkhs (rxbyteclkhs),
		.rst_n_i     (rst_n_i),
		.host_stb_i  (host_stb_i),
		.host_we_i   (host_we_i),
		.host_adr_i  (host_adr_i),
		.host_dat_i  (host_dat_i),
		.host_dat_o  (host_dat_o),
		.host_ack_o  (host_ack_o),
		.len0_i      (len0),
		.len1_i      (len1),
		.ctrl        (ctrl_if.regs)
	);

endmodule

/* test/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------------------------------------
// Random data and lane stimulus
// --------------------------------------------------
function automatic logic lfsr_bit();
	logic fb;
	fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1
	lfsr = {lfsr[30:0], fb};
	return fb;
endfunction

function automatic byte_t rand_byte();
	byte_t b;
	b = '0;
	for (int i = 0; i < 8; i++) b = {b[6:0], lfsr_bit()};
	return b;
endfunction

function automatic int rand_len();
	return int'(rand_byte()) % 20 + 1;  // 1 to 20
endfunction

function automatic lane_word_t pack_lane(byte_t d, logic v, logic a, logic s, logic e, logic es);
	return {3'b000, es, e, s, a, v, d};
endfunction

// Beat c of a burst is sync first, then n data bytes, then idle
function automatic lane_word_t lane_beat(int c, int n, logic errsot, logic errsotsync);
	if (c == 0) return pack_lane(SYNC_BYTE, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
	if (c <= n) return pack_lane(rand_byte(), 1'b1, 1'b1, 1'b0, errsot, errsotsync);
	return '0;
endfunction

task automatic drive_lanes(input lane_word_t w0, input lane_word_t w1);
	dl0_rxdatahs_i     = w0[7:0];
	dl0_rxvalidhs_i    = w0[8];
	dl0_rxactivehs_i   = w0[9];
	dl0_rxsynchs_i     = w0[10];
	dl0_errsoths_i     = w0[11];
	dl0_errsotsynchs_i = w0[12];
	dl1_rxdatahs_i     = w1[7:0];
	dl1_rxvalidhs_i    = w1[8];
	dl1_rxactivehs_i   = w1[9];
	dl1_rxsynchs_i     = w1[10];
	dl1_errsoths_i     = w1[11];
	dl1_errsotsynchs_i = w1[12];
endtask

task automatic send_burst(input int n0, input int n1, input int idle, input int err_byte);
	int         total;
	logic       err;
	lane_word_t w0;
	lane_word_t w1;
	exp_words.delete();
	total = 1 + ((n0 > n1) ? n0 : n1);
	for (int c = 0; c < total + idle; c++) begin
		err = (err_byte >= 0) && (c - 1 == err_byte);
		w0  = lane_beat(c, n0, err, 1'b0);  // Errsot on lane 0
		w1  = lane_beat(c, n1, 1'b0, err);  // Errsotsync on lane 1
		@(posedge rxbyteclkhs);
		#DRIVE_DLY;
		drive_lanes(w0, w1);
		if (w0[LW_ACTIVE_BIT] || w1[LW_ACTIVE_BIT]) exp_words.push_back({w1, w0});
	end
endtask

// --------------------------------------------------
// Register bus
// --------------------------------------------------
function automatic bus_adr_t reg_adr(logic [7:0] off);
	return {PAGE_REGS, off};
endfunction

function automatic bus_adr_t buf_adr(buf_idx_t idx);
	return {PAGE_BUF, 2'b00, idx};
endfunction

function automatic bus_dat_t status_word(int cnt, logic full);
	bus_dat_t s;
	s      = '0;
	s[6:0] = cnt[6:0];
	s[8]   = full;
	return s;
endfunction

task automatic wait_ack(input logic level);
	int n;
	n = 0;
	@(negedge rxbyteclkhs);
	while (host_ack_o !== level && n < ACK_LIMIT) begin
		@(negedge rxbyteclkhs);
		n++;
	end
	if (host_ack_o !== level) begin
		$display("Bus handshake stuck at address 0x%h: ack did not go to %0d within %0d cycles",
			host_adr_i, level, ACK_LIMIT);
		hs_errors++;
	end
endtask

task automatic bus_cycle(input logic we, input bus_adr_t adr, input bus_dat_t wdat,
		output bus_dat_t rdat);
	@(posedge rxbyteclkhs);
	#DRIVE_DLY;
	host_adr_i = adr;
	host_we_i  = we;
	host_dat_i = wdat;
	host_stb_i = 1'b1;
	wait_ack(1'b1);
	rdat = host_dat_o;  // Stable while ack is high
	@(posedge rxbyteclkhs);
	#DRIVE_DLY;
	host_stb_i = 1'b0;
	host_we_i  = 1'b0;
	wait_ack(1'b0);
endtask

task automatic bus_write(input bus_adr_t adr, input bus_dat_t dat);
	bus_dat_t unused;
	bus_cycle(1'b1, adr, dat, unused);
endtask

task automatic bus_read(input bus_adr_t adr, output bus_dat_t dat);
	bus_cycle(1'b0, adr, '0, dat);
endtask

// --------------------------------------------------
// Compare
// --------------------------------------------------
task automatic check_dat(input string name, input bus_dat_t exp, input bus_dat_t act);
	if (act !== exp) begin
		$display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
		val_errors++;
	end
endtask

task automatic check_len(input string name, input pkt_len_t exp, input pkt_len_t act);
	if (act !== exp) begin
		$display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
		val_errors++;
	end
endtask

task automatic check_word(input string name, input cap_word_t exp, input cap_word_t act);
	if (act !== exp) begin
		$display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
		val_errors++;
	end
endtask

`endif

/* test/tb_dphy_capture_top.sv */
`timescale 1ns/1ps

module tb_dphy_capture_top;
	import dphy_capture_pkg::*;

	localparam int       NUM_TESTS       = 6;
	localparam int       WATCHDOG_CYCLES = NUM_TESTS * 2000;
	localparam int       ACK_LIMIT       = 16;
	localparam int       DRIVE_DLY       = 2;
	localparam byte_t    SYNC_BYTE       = 8'hb8;
	localparam bus_dat_t CTRL_EN         = bus_dat_t'(1) << CTRL_ENABLE_BIT;
	localparam bus_dat_t CTRL_CLR        = bus_dat_t'(1) << CTRL_CLEAR_BIT;

	logic     rxbyteclkhs;
	logic     rst_n_i;
	byte_t    dl0_rxdatahs_i;
	byte_t    dl1_rxdatahs_i;
	logic     dl0_rxvalidhs_i, dl0_rxactivehs_i, dl0_rxsynchs_i;
	logic     dl0_errsoths_i, dl0_errsotsynchs_i;
	logic     dl1_rxvalidhs_i, dl1_rxactivehs_i, dl1_rxsynchs_i;
	logic     dl1_errsoths_i, dl1_errsotsynchs_i;
	logic     host_stb_i, host_we_i, host_ack_o;
	bus_adr_t host_adr_i;
	bus_dat_t host_dat_i;
	bus_dat_t host_dat_o;

	logic [31:0] lfsr;
	int          val_errors;
	int          hs_errors;
	cap_word_t   exp_words [$];  // Packed lane words of the last burst

	`include "tb_tasks.svh"

	dphy_capture_top u_dphy_capture_top (.*);

	always #10 rxbyteclkhs = ~rxbyteclkhs;

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic id_and_unmapped_reads();
		bus_dat_t d;
		bus_read(reg_adr(ADR_ID), d);
		check_dat("host_dat_o ID", GLOBAL_ID, d);
		bus_read(10'h300, d);
		check_dat("host_dat_o unmapped", '0, d);
	endtask

	task automatic ctrl_status_reset();
		bus_dat_t d;
		bus_read(reg_adr(ADR_CTRL), d);
		check_dat("host_dat_o CTRL", '0, d);
		bus_read(reg_adr(ADR_STATUS), d);
		check_dat("host_dat_o STATUS", '0, d);
		bus_write(reg_adr(ADR_CTRL), CTRL_EN);
		bus_read(reg_adr(ADR_CTRL), d);
		check_dat("host_dat_o CTRL enable", CTRL_EN, d);
		bus_write(reg_adr(ADR_CTRL), CTRL_EN | CTRL_CLR);
		bus_read(reg_adr(ADR_CTRL), d);
		check_dat("host_dat_o CTRL clear", CTRL_EN, d);  // Clear bit self-clears
	endtask

	task automatic lengths_match(input int n0, input int n1);
		bus_dat_t d;
		bus_read(reg_adr(ADR_LEN0), d);
		check_len("pkt_len lane 0", pkt_len_t'(n0), d[15:0]);
		bus_read(reg_adr(ADR_LEN1), d);
		check_len("pkt_len lane 1", pkt_len_t'(n1), d[15:0]);
	endtask

	task automatic packet_lengths();
		int n0;
		int n1;
		n0 = rand_len();
		n1 = rand_len();
		send_burst(n0, n1, 4, -1);
		lengths_match(n0, n1);
	endtask

	task automatic verify_buffer();
		int       cnt;
		bus_dat_t d;
		cnt = (exp_words.size() > BUF_DEPTH) ? BUF_DEPTH : exp_words.size();
		bus_read(reg_adr(ADR_STATUS), d);
		check_dat("host_dat_o STATUS", status_word(cnt, exp_words.size() >= BUF_DEPTH), d);
		for (int i = 0; i < cnt; i++) begin
			bus_read(buf_adr(buf_idx_t'(i)), d);
			check_word($sformatf("rd_data word %0d", i), exp_words[i], d);
		end
	endtask

	task automatic capture_contents();
		bus_write(reg_adr(ADR_CTRL), CTRL_EN);
		bus_write(reg_adr(ADR_CTRL), CTRL_EN | CTRL_CLR);
		send_burst(rand_len(), rand_len(), 4, 0);  // Error flags on first data byte
		verify_buffer();
	endtask

	task automatic full_then_clear();
		bus_dat_t d;
		bus_write(reg_adr(ADR_CTRL), CTRL_EN | CTRL_CLR);
		send_burst(BUF_DEPTH + 6, 40, 4, -1);
		verify_buffer();
		bus_write(reg_adr(ADR_CTRL), CTRL_EN | CTRL_CLR);
		bus_read(reg_adr(ADR_STATUS), d);
		check_dat("host_dat_o STATUS after clear", '0, d);
	endtask

	task automatic disabled_capture();
		int       n0;
		int       n1;
		bus_dat_t d;
		n0 = rand_len();
		n1 = rand_len();
		bus_write(reg_adr(ADR_CTRL), CTRL_CLR);  // Enable off and buffer emptied
		send_burst(n0, n1, 4, -1);
		bus_read(reg_adr(ADR_STATUS), d);
		check_dat("host_dat_o STATUS disabled", '0, d);
		lengths_match(n0, n1);
	endtask

	// --------------------------------------------------
	// Sequence and watchdog
	// --------------------------------------------------
	initial begin
		rxbyteclkhs = 1'b0;
		rst_n_i     = 1'b0;
		host_stb_i  = 1'b0;
		host_we_i   = 1'b0;
		host_adr_i  = '0;
		host_dat_i  = '0;
		lfsr        = 32'h410eb60b;
		val_errors  = 0;
		hs_errors   = 0;
		drive_lanes('0, '0);
		repeat (4) @(posedge rxbyteclkhs);
		#DRIVE_DLY;
		rst_n_i = 1'b1;
		id_and_unmapped_reads();
		ctrl_status_reset();
		packet_lengths();
		capture_contents();
		full_then_clear();
		disabled_capture();
		$display("Errors: %0d value mismatches, %0d bus handshake failures",
			val_errors, hs_errors);
		if (val_errors == 0 && hs_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge rxbyteclkhs);
		$display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* dphy_capture_top.f */
+incdir+test
src/dphy_capture_pkg.sv
src/dphy_lane_if.sv
src/capture_ctrl_if.sv
src/dphy_lane_monitor.sv
src/capture_buffer.sv
src/capture_regs.sv
src/dphy_capture_top.sv
test/tb_dphy_capture_top.sv

/* run_sim.sh */
#!/bin/sh
LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_dphy_capture_top -Mdir obj_dir \
	-f dphy_capture_top.f > "$LOG" 2>&1 \
	&& ./obj_dir/Vtb_dphy_capture_top >> "$LOG" 2>&1
cat "$LOG"
grep -q "^Result: PASSED$" "$LOG" && echo "Simulation passed" \
	|| { echo "Simulation failed, see $LOG"; exit 1; }
